//--- flist.f
+incdir+include
hw/rv_pkg.sv
hw/stream_if.sv
hw/alu.sv
hw/gpr_file.sv
hw/op_fifo.sv
hw/fetch_decode.sv
hw/exec_unit.sv
hw/rv_core.sv
testbench/tb_rv_core.sv

//--- hw/alu.sv
////////////////////
// RV32I integer ALU
////////////////////
`timescale 1ns/1ns

module alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_op_e         op,
    output logic [rv_pkg::xlen-1:0] result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Only low 5 bits shift

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = xlen'($signed(a) < $signed(b));
            alu_sltu: result = xlen'(a < b);
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;  // Arithmetic, keeps sign
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

//--- hw/exec_unit.sv
////////////////////
// Execute stage: operands, ALU, branches,
// write-back and retire record
////////////////////
`timescale 1ns/1ns

module exec_unit (
    input  logic                          clk,
    input  logic                          reset,
    stream_if.consumer                    op,
    stream_if.producer                    ret,
    output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [rv_pkg::xlen-1:0]       rs1_data,
    input  logic [rv_pkg::xlen-1:0]       rs2_data,
    output logic                          wr_en,
    output logic [rv_pkg::reg_addr_w-1:0] wr_addr,
    output logic [rv_pkg::xlen-1:0]       wr_data,
    output logic                          redirect,
    output logic [rv_pkg::xlen-1:0]       redirect_pc
);
    import rv_pkg::*;

    decoded_op_t     cur;
    retire_t         rec;
    alu_op_e         alu_op;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] target;
    logic            fire;
    logic            taken;
    logic            writes;
    logic            is_jump;
    logic            br_cond;

    assign cur      = op.payload;
    assign rs1_addr = cur.rs1;
    assign rs2_addr = cur.rs2;

    // Head is wrong-path while redirect is up, so hold it
    assign op.ready  = ret.ready && !redirect;
    assign ret.valid = op.valid && !redirect;
    assign fire      = op.valid && ret.ready && !redirect;

    always_comb begin
        case (cur.inst_type)
            type_r: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
            type_i: begin
                alu_a = rs1_data;
                alu_b = cur.imm;
            end
            type_u: begin
                alu_a = (cur.opcode == op_lui) ? '0 : cur.pc;
                alu_b = cur.imm;
            end
            type_j, type_b: begin
                alu_a = cur.pc;  // Target computed in the ALU
                alu_b = cur.imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
        endcase
    end

    always_comb begin
        alu_op = alu_add;
        if (cur.opcode == op_imm || cur.opcode == op_reg) begin
            case (cur.funct3)
                3'b000: alu_op = (cur.inst_type == type_r && cur.funct7_b5) ? alu_sub : alu_add;
                3'b001: alu_op = alu_sll;
                3'b010: alu_op = alu_slt;
                3'b011: alu_op = alu_sltu;
                3'b100: alu_op = alu_xor;
                3'b101: alu_op = cur.funct7_b5 ? alu_sra : alu_srl;
                3'b110: alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    alu i_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    always_comb begin
        case (cur.funct3)
            f3_beq:  br_cond = (rs1_data == rs2_data);
            f3_bne:  br_cond = (rs1_data != rs2_data);
            f3_blt:  br_cond = ($signed(rs1_data) < $signed(rs2_data));
            f3_bge:  br_cond = ($signed(rs1_data) >= $signed(rs2_data));
            f3_bltu: br_cond = (rs1_data < rs2_data);
            f3_bgeu: br_cond = (rs1_data >= rs2_data);
            default: br_cond = 1'b0;
        endcase
    end

    always_comb begin
        writes  = 1'b0;
        taken   = 1'b0;
        is_jump = 1'b0;
        target  = alu_result;
        case (cur.opcode)
            op_reg, op_imm, op_lui, op_auipc: writes = 1'b1;
            op_jal: begin
                writes  = 1'b1;
                taken   = 1'b1;
                is_jump = 1'b1;
            end
            op_jalr: begin
                writes  = 1'b1;
                taken   = 1'b1;
                is_jump = 1'b1;
                target  = {alu_result[xlen-1:1], 1'b0};
            end
            op_branch: taken = br_cond;
            default: ;  // Unknown opcode retires as a no-op
        endcase
    end

    always_comb begin
        rec.pc   = cur.pc;
        rec.rd   = cur.rd;
        rec.data = is_jump ? cur.pc + xlen'(4) : alu_result;  // Link address for jumps
        rec.we   = writes && (cur.rd != '0);
    end

    assign ret.payload = rec;
    assign wr_en       = fire && rec.we;
    assign wr_addr     = cur.rd;
    assign wr_data     = rec.data;

    // One-cycle pulse after a taken transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            redirect <= 1'b0;
        end else begin
            redirect <= fire && taken;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && taken) redirect_pc <= target;
    end

endmodule

//--- hw/fetch_decode.sv
////////////////////
// Fetch/decode stage: PC, instruction
// handshake and RV32I field decode
////////////////////
`timescale 1ns/1ns

module fetch_decode #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    reset,
    output logic [rv_pkg::xlen-1:0] fetch_pc,
    input  logic                    inst_valid,
    input  logic [rv_pkg::xlen-1:0] inst,
    output logic                    inst_ready,
    input  logic                    redirect,
    input  logic [rv_pkg::xlen-1:0] redirect_pc,
    stream_if.producer              dec
);
    import rv_pkg::*;

    logic                accept;
    logic [opcode_w-1:0] opcode;
    inst_type_e          inst_type;
    logic [xlen-1:0]     imm;
    decoded_op_t         op;

    // Instructions are only taken when the op FIFO has room
    assign inst_ready = dec.ready;
    assign accept     = inst_valid && dec.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= reset_pc;
        end else if (redirect) begin
            fetch_pc <= redirect_pc;  // Wrong-path fetch abandoned
        end else if (accept) begin
            fetch_pc <= fetch_pc + xlen'(4);
        end
    end

    assign opcode = inst[6:0];

    // Format classification
    always_comb begin
        case (opcode)
            op_reg:            inst_type = type_r;
            op_imm, op_jalr:   inst_type = type_i;
            op_lui, op_auipc:  inst_type = type_u;
            op_jal:            inst_type = type_j;
            op_branch:         inst_type = type_b;
            default:           inst_type = type_n;
        endcase
    end

    // Sign-extended immediates
    always_comb begin
        case (inst_type)
            type_i: imm = {{20{inst[31]}}, inst[31:20]};
            type_b: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            type_u: imm = {inst[31:12], 12'b0};
            type_j: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

    always_comb begin
        op.pc        = fetch_pc;
        op.opcode    = opcode;
        op.funct3    = inst[14:12];
        op.funct7_b5 = inst[30];
        op.rd        = inst[11:7];
        op.rs1       = inst[19:15];
        op.rs2       = inst[24:20];
        op.imm       = imm;
        op.inst_type = inst_type;
    end

    assign dec.payload = op;
    assign dec.valid   = inst_valid && !redirect;  // Drop the op taken at a redirect edge

endmodule

//--- hw/gpr_file.sv
////////////////////
// Register file, x0 reads as zero
////////////////////
`timescale 1ns/1ns

module gpr_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr2,
    output logic [rv_pkg::xlen-1:0]       rdata1,
    output logic [rv_pkg::xlen-1:0]       rdata2,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv_pkg::xlen-1:0]       wdata
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Index 0 never returns stored data
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hw/op_fifo.sv
////////////////////
// Flushable FIFO, payload type as parameter
////////////////////
`timescale 1ns/1ns

module op_fifo #(
    parameter type payload_t  = logic,
    parameter int  fifo_depth = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    stream_if.consumer in,
    stream_if.producer out
);
    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    payload_t         mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] count_next;
    logic             not_full;  // Registered so ready is low through reset
    logic             push;
    logic             pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push       = in.valid && not_full && !flush;
    assign pop        = out.valid && out.ready && !flush;
    assign count_next = count + cnt_w'(push) - cnt_w'(pop);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            not_full <= 1'b0;
        end else if (flush) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            not_full <= 1'b1;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            count    <= count_next;
            not_full <= (count_next != cnt_w'(fifo_depth));
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in.payload;
    end

    assign in.ready    = not_full;
    assign out.valid   = (count != '0);
    assign out.payload = mem[rd_ptr];

endmodule

//--- hw/rv_core.sv
////////////////////
// RV32I pipelined core top level
////////////////////
`timescale 1ns/1ns

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc   = '0,
    parameter int                      fifo_depth = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    output logic [rv_pkg::xlen-1:0]       fetch_pc,
    input  logic                          inst_valid,
    input  logic [rv_pkg::xlen-1:0]       inst,
    output logic                          inst_ready,
    output logic                          retire_valid,
    input  logic                          retire_ready,
    output logic [rv_pkg::xlen-1:0]       retire_pc,
    output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_pkg::xlen-1:0]       retire_data,
    output logic                          retire_we
);
    import rv_pkg::*;

    logic                  redirect;
    logic [xlen-1:0]       redirect_pc;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs1_data;
    logic [xlen-1:0]       rs2_data;
    logic                  wr_en;
    logic [reg_addr_w-1:0] wr_addr;
    logic [xlen-1:0]       wr_data;
    retire_t               ret_rec;

    stream_if #(.payload_t(decoded_op_t)) dec_to_buf (.clk(clk));
    stream_if #(.payload_t(decoded_op_t)) buf_to_exe (.clk(clk));
    stream_if #(.payload_t(retire_t))     exe_to_ret (.clk(clk));
    stream_if #(.payload_t(retire_t))     ret_out    (.clk(clk));

    fetch_decode #(.reset_pc(reset_pc)) i_fetch_decode (
        .clk(clk), .reset(reset), .fetch_pc(fetch_pc), .inst_valid(inst_valid),
        .inst(inst), .inst_ready(inst_ready), .redirect(redirect),
        .redirect_pc(redirect_pc), .dec(dec_to_buf)
    );

    // Op buffer, flushed on a taken transfer
    op_fifo #(.payload_t(decoded_op_t), .fifo_depth(fifo_depth)) i_op_fifo (
        .clk(clk), .reset(reset), .flush(redirect), .in(dec_to_buf), .out(buf_to_exe)
    );

    exec_unit i_exec_unit (
        .clk(clk), .reset(reset), .op(buf_to_exe), .ret(exe_to_ret),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .redirect(redirect), .redirect_pc(redirect_pc)
    );

    gpr_file i_gpr_file (
        .clk(clk), .reset(reset), .raddr1(rs1_addr), .raddr2(rs2_addr),
        .rdata1(rs1_data), .rdata2(rs2_data), .we(wr_en), .waddr(wr_addr),
        .wdata(wr_data)
    );

    op_fifo #(.payload_t(retire_t), .fifo_depth(fifo_depth)) i_ret_fifo (
        .clk(clk), .reset(reset), .flush(1'b0), .in(exe_to_ret), .out(ret_out)
    );

    // Retire stream onto plain ports
    assign ret_out.ready = retire_ready;
    assign retire_valid  = ret_out.valid;
    assign ret_rec       = ret_out.payload;
    assign retire_pc     = ret_rec.pc;
    assign retire_rd     = ret_rec.rd;
    assign retire_data   = ret_rec.data;
    assign retire_we     = ret_rec.we;

endmodule

//--- hw/rv_pkg.sv
////////////////////
// RV32I opcodes, field widths, decode enums
// and the stream payload structs
////////////////////
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 7;

    // Kept opcodes
    localparam logic [opcode_w-1:0] op_lui    = 7'b0110111;
    localparam logic [opcode_w-1:0] op_auipc  = 7'b0010111;
    localparam logic [opcode_w-1:0] op_jal    = 7'b1101111;
    localparam logic [opcode_w-1:0] op_jalr   = 7'b1100111;
    localparam logic [opcode_w-1:0] op_branch = 7'b1100011;
    localparam logic [opcode_w-1:0] op_imm    = 7'b0010011;
    localparam logic [opcode_w-1:0] op_reg    = 7'b0110011;

    // Branch conditions, funct3 field
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [2:0] {
        type_r,  // Register-register
        type_i,  // Register-immediate and JALR
        type_u,  // LUI, AUIPC
        type_j,  // JAL
        type_b,  // Conditional branches
        type_n   // Anything else
    } inst_type_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // Decode to execute
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [opcode_w-1:0]   opcode;
        logic [2:0]            funct3;
        logic                  funct7_b5;  // SUB / SRA select
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       imm;
        inst_type_e            inst_type;
    } decoded_op_t;

    // Execute to retire
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
        logic                  we;  // Register actually written
    } retire_t;

endpackage

//--- hw/stream_if.sv
////////////////////
// Valid/ready stream with typed payload
////////////////////
`timescale 1ns/1ns

interface stream_if #(
    parameter type payload_t = logic
) (
    input logic clk
);
    logic     valid;
    logic     ready;
    payload_t payload;  // Held stable while valid waits for ready

    modport producer (input clk, input ready, output valid, output payload);

    modport consumer (input clk, input valid, input payload, output ready);

endinterface

//--- include/tb_rv_model.svh
////////////////////
// Reference model, xorshift generator
// and RV32I instruction encoders
////////////////////
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

localparam logic [6:0] opc_lui    = 7'b0110111;
localparam logic [6:0] opc_auipc  = 7'b0010111;
localparam logic [6:0] opc_jal    = 7'b1101111;
localparam logic [6:0] opc_jalr   = 7'b1100111;
localparam logic [6:0] opc_branch = 7'b1100011;
localparam logic [6:0] opc_imm    = 7'b0010011;
localparam logic [6:0] opc_reg    = 7'b0110011;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_reg};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

// Byte offset, bit 0 dropped by the format
function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << sh;
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) return $signed(a) >>> sh;  // Sign fill
            return a >> sh;
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] a,
                                input logic [31:0] b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        3'd7: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// Steps the loaded program in order and queues the expected retire records
task automatic model_run();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] res;
    logic [31:0] nxt;
    logic        wr;
    int          steps;
    exp_rec_t    rec;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    exp_q.delete();
    pc    = '0;
    steps = 0;
    while ((pc >> 2) < prog_len && steps < 1000) begin
        w     = imem[pc[9:2]];
        a     = regs[w[19:15]];
        b     = regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        res   = '0;
        wr    = 1'b1;
        nxt   = pc + 4;
        case (w[6:0])
            opc_lui:   res = {w[31:12], 12'b0};
            opc_auipc: res = pc + {w[31:12], 12'b0};
            opc_jal: begin
                res = pc + 4;
                nxt = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            opc_jalr: begin
                res = pc + 4;
                nxt = (a + imm_i) & ~32'd1;
            end
            opc_branch: begin
                wr = 1'b0;
                if (br_ref(w[14:12], a, b)) begin
                    nxt = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            opc_imm: res = alu_ref(w[14:12], (w[14:12] == 3'd5) && w[30], a, imm_i);
            opc_reg: res = alu_ref(w[14:12], w[30], a, b);
            default: wr = 1'b0;  // Retires as a no-op
        endcase
        rec.pc   = pc;
        rec.rd   = w[11:7];
        rec.data = res;
        rec.we   = wr && (w[11:7] != 5'd0);
        if (rec.we) regs[w[11:7]] = res;
        exp_q.push_back(rec);
        pc = nxt;
        steps++;
    end
endtask

`endif

//--- testbench/tb_rv_core.sv
////////////////////
// rv_core testbench with instruction memory,
// directed tests and retire checking
////////////////////
`timescale 1ns/1ns

module tb_rv_core;

    localparam int fifo_depth   = 2;
    localparam int reset_cycles = 16;
    localparam int imem_words   = 256;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        we;
    } exp_rec_t;

    logic        clk;
    logic        reset;
    logic [31:0] fetch_pc;
    logic        inst_valid;
    logic [31:0] inst;
    logic        inst_ready;
    logic        retire_valid;
    logic        retire_ready;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        retire_we;

    logic [31:0] imem [imem_words];
    int          prog_len;
    exp_rec_t    exp_q [$];
    logic [31:0] rng;
    logic        bp_mode;
    int          stall_left;
    int          errors;
    int          checked;
    int          run_cycles;
    int          run_limit;

    `include "tb_rv_model.svh"

    rv_core i_dut (
        .clk(clk), .reset(reset), .fetch_pc(fetch_pc), .inst_valid(inst_valid),
        .inst(inst), .inst_ready(inst_ready), .retire_valid(retire_valid),
        .retire_ready(retire_ready), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_data(retire_data), .retire_we(retire_we)
    );

    always #20 clk = ~clk;

    // Instruction memory and retire back-pressure on the falling edge
    always @(negedge clk) begin
        inst_valid <= ((fetch_pc >> 2) < prog_len);
        inst       <= imem[fetch_pc[9:2]];
        if (!bp_mode) begin
            retire_ready <= 1'b1;
        end else if (stall_left != 0) begin
            retire_ready <= 1'b0;
            stall_left--;
        end else begin
            rng = xorshift32(rng);
            if (rng[2:0] == 3'd0) begin
                stall_left = 4 + rng[7:4];  // Long stall
                retire_ready <= 1'b0;
            end else begin
                retire_ready <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin : retire_monitor
        exp_rec_t e;
        if (!reset && retire_valid && retire_ready) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t ns: retire of pc %h with no record expected",
                         $time, retire_pc);
                errors++;
            end else begin
                e = exp_q.pop_front();
                checked++;
                if (retire_pc !== e.pc) begin
                    $display("Fail at %0t ns: retire_pc = %h, expected %h",
                             $time, retire_pc, e.pc);
                    errors++;
                end
                if (retire_we !== e.we) begin
                    $display("Fail at %0t ns: retire_we = %b, expected %b",
                             $time, retire_we, e.we);
                    errors++;
                end
                if (e.we && retire_rd !== e.rd) begin
                    $display("Fail at %0t ns: retire_rd = %0d, expected %0d",
                             $time, retire_rd, e.rd);
                    errors++;
                end
                if (e.we && retire_data !== e.data) begin
                    $display("Fail at %0t ns: retire_data = %h, expected %h",
                             $time, retire_data, e.data);
                    errors++;
                end
            end
        end
        if (!reset && inst_ready && i_dut.i_op_fifo.count == fifo_depth
                && i_dut.i_ret_fifo.count == fifo_depth) begin
            $display("Error at %0t ns: inst_ready high while both FIFOs are full", $time);
            errors++;
        end
    end

    task automatic print_counts();
        $display("Checked %0d retire records, %0d errors", checked, errors);
    endtask

    // Ends a program run that stops retiring
    always @(posedge clk) begin : watchdog
        if (run_limit != 0) begin
            run_cycles++;
            if (run_cycles > run_limit) begin
                $display("Timeout after %0d cycles, %0d retire records never arrived",
                         run_cycles, exp_q.size());
                print_counts();
                $display("SIMULATION FAILED");
                $finish;
            end
        end
    end

    // Holds the core in reset while a new program is loaded
    task automatic begin_program();
        @(negedge clk);
        reset    = 1'b1;
        prog_len = 0;
    endtask

    task automatic emit(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    // Core outputs at the end of reset
    task automatic check_reset_state();
        if (fetch_pc !== 32'd0) begin
            $display("Fail at %0t ns: fetch_pc = %h, expected %h", $time, fetch_pc, 32'd0);
            errors++;
        end
        if (inst_ready !== 1'b0) begin
            $display("Fail at %0t ns: inst_ready = %b, expected %b",
                     $time, inst_ready, 1'b0);
            errors++;
        end
        if (retire_valid !== 1'b0) begin
            $display("Fail at %0t ns: retire_valid = %b, expected %b",
                     $time, retire_valid, 1'b0);
            errors++;
        end
    endtask

    task automatic run_program(input logic bp);
        model_run();
        repeat (reset_cycles) @(negedge clk);
        check_reset_state();
        reset      = 1'b0;
        run_cycles = 0;
        run_limit  = 20 * prog_len + reset_cycles;
        @(posedge clk);
        bp_mode = bp;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        run_limit = 0;
        @(posedge clk);
        bp_mode = 1'b0;
        repeat (8) @(negedge clk);  // Window for stray retires
    endtask

    task automatic build_alu_prog();
        logic [11:0] imm;
        begin_program();
        for (int round = 0; round < 3; round++) begin
            rng = xorshift32(rng);
            emit(enc_u(rng[31:12], 5'd1, opc_lui));
            emit(enc_i(rng[11:0], 5'd1, 3'd0, 5'd1, opc_imm));
            rng = xorshift32(rng);
            emit(enc_u(rng[31:12], 5'd2, opc_lui));
            emit(enc_i(rng[11:0], 5'd2, 3'd0, 5'd2, opc_imm));
            for (int f = 0; f < 8; f++) begin
                emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'(3 + f)));
            end
            emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd11));  // SUB
            emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd12));  // SRA
            for (int f = 0; f < 8; f++) begin
                rng = xorshift32(rng);
                imm = (f == 1 || f == 5) ? {7'h00, rng[4:0]} : rng[11:0];
                emit(enc_i(imm, 5'd1, 3'(f), 5'(13 + f), opc_imm));
            end
            emit(enc_i({7'h20, rng[9:5]}, 5'd1, 3'd5, 5'd21, opc_imm));  // SRAI
        end
    endtask

    task automatic build_branch_prog();
        begin_program();
        emit(enc_i(12'hffb, 5'd0, 3'd0, 5'd1, opc_imm));  // x1 = -5
        emit(enc_i(12'd3, 5'd0, 3'd0, 5'd2, opc_imm));
        emit(enc_i(12'd3, 5'd0, 3'd0, 5'd3, opc_imm));
        emit(enc_i(12'd3, 5'd0, 3'd0, 5'd4, opc_imm));
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) continue;
            // Each branch skips one increment of x5 when taken
            emit(enc_b(13'd8, 5'd2, 5'd1, 3'(f)));
            emit(enc_i(12'd1, 5'd5, 3'd0, 5'd5, opc_imm));
            emit(enc_b(13'd8, 5'd1, 5'd2, 3'(f)));
            emit(enc_i(12'd1, 5'd5, 3'd0, 5'd5, opc_imm));
            emit(enc_b(13'd8, 5'd4, 5'd3, 3'(f)));
            emit(enc_i(12'd1, 5'd5, 3'd0, 5'd5, opc_imm));
        end
        emit(enc_i(12'd3, 5'd0, 3'd0, 5'd6, opc_imm));
        emit(enc_i(12'hfff, 5'd6, 3'd0, 5'd6, opc_imm));  // Backward loop runs three passes
        emit(enc_b(-13'sd4, 5'd0, 5'd6, 3'd1));
        emit(enc_r(7'h00, 5'd5, 5'd6, 3'd0, 5'd7));
    endtask

    task automatic test_alu_ops();
        build_alu_prog();
        run_program(1'b0);
    endtask

    task automatic test_upper_imm();
        begin_program();
        for (int k = 1; k < 13; k++) begin
            rng = xorshift32(rng);
            emit(enc_u(rng[31:12], 5'(k), (k % 2) ? opc_lui : opc_auipc));
        end
        run_program(1'b0);
    endtask

    task automatic test_branches();
        build_branch_prog();
        run_program(1'b0);
    endtask

    task automatic test_jumps();
        begin_program();
        emit(enc_j(21'd12, 5'd1));                          // pc 0 jumps to 12
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd5, opc_imm));
        emit(enc_i(12'd2, 5'd0, 3'd0, 5'd6, opc_imm));
        emit(enc_i(12'd33, 5'd0, 3'd0, 5'd7, opc_imm));    // pc 12
        emit(enc_i(12'd0, 5'd7, 3'd0, 5'd2, opc_jalr));    // Odd target 33 from pc 16
        for (int k = 0; k < 3; k++) begin
            emit(enc_i(12'd3, 5'd0, 3'd0, 5'd8, opc_imm));
        end
        emit(enc_i(12'd7, 5'd0, 3'd0, 5'd9, opc_imm));     // pc 32
        emit(enc_j(21'd8, 5'd0));                           // pc 36 jumps to 44 without link
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd10, opc_imm));
        emit(enc_i(12'd1, 5'd2, 3'd0, 5'd11, opc_imm));    // pc 44
        emit(enc_i(12'd49, 5'd1, 3'd0, 5'd12, opc_jalr));  // 4 + 49 from pc 48 lands on 52
        emit(enc_i(12'd0, 5'd12, 3'd0, 5'd13, opc_imm));   // pc 52
        run_program(1'b0);
    endtask

    task automatic test_x0();
        begin_program();
        emit(enc_i(12'd9, 5'd0, 3'd0, 5'd1, opc_imm));
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd0, opc_imm));
        emit(enc_u(20'h12345, 5'd0, opc_lui));
        emit(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
        emit(enc_j(21'd4, 5'd0));
        emit(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd2));
        emit(enc_r(7'h00, 5'd1, 5'd0, 3'd6, 5'd3));
        emit(enc_i(12'd0, 5'd0, 3'd0, 5'd4, opc_imm));
        emit(enc_r(7'h20, 5'd1, 5'd0, 3'd0, 5'd5));
        run_program(1'b0);
    endtask

    task automatic test_back_pressure();
        build_alu_prog();
        run_program(1'b1);
        build_branch_prog();
        run_program(1'b1);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        retire_ready = 1'b0;
        rng          = 32'd88;
        bp_mode      = 1'b0;
        stall_left   = 0;
        prog_len     = 0;
        errors       = 0;
        checked      = 0;
        run_cycles   = 0;
        run_limit    = 0;
        test_alu_ops();
        test_upper_imm();
        test_branches();
        test_jumps();
        test_x0();
        test_back_pressure();
        print_counts();
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
